/* filelist.f */
+incdir+src
src/x25519_pkg.sv
src/reduction_adder.sv
src/mult_pass_products.sv
src/mult_pass.sv
src/carry_squeeze.sv
src/x25519_mult.sv
tests/tb_x25519_mult.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the x25519 multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_x25519_mult \
	--Mdir obj_dir \
	-f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_x25519_mult)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* src/carry_squeeze.sv */
`timescale 1ns/1ns
`include "x25519_cfg.svh"

module carry_squeeze (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  sq_start,
	input  x25519_pkg::bignum32_t wide,
	output logic                  sq_done,
	output x25519_pkg::bignum_t   sq_result
);

	localparam int N     = `X25519_LIMBS;
	localparam int W     = `X25519_WORD_WIDTH;
	localparam int LW    = `X25519_LIMB_WIDTH;
	localparam int IDX_W = $clog2(`X25519_LIMBS);

	x25519_pkg::squeeze_state_t state;
	x25519_pkg::bignum32_t      limbs;
	logic [W-1:0]               carry;
	logic [IDX_W-1:0]           idx;
	logic [W-1:0]               sum;

	// Current limb plus running carry, idx sits on the top limb in fold states
	assign sum = limbs.blocks[idx] + carry;

	////////////////////////////////////////////////////////////
	// FSM, 31 carries, fold, 31 carries, fold

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= x25519_pkg::SQ_IDLE;
			idx     <= '0;
			sq_done <= 1'b0;
		end else begin
			sq_done <= 1'b0;
			case (state)
				x25519_pkg::SQ_IDLE: begin
					if (sq_start) begin
						state <= x25519_pkg::SQ_CARRY1;
						idx   <= '0;
					end
				end
				x25519_pkg::SQ_CARRY1: begin
					idx <= idx + 1'b1;
					if (idx == IDX_W'(N - 2)) begin
						state <= x25519_pkg::SQ_FOLD1;
					end
				end
				x25519_pkg::SQ_FOLD1: begin
					state <= x25519_pkg::SQ_CARRY2;
					idx   <= '0;
				end
				x25519_pkg::SQ_CARRY2: begin
					idx <= idx + 1'b1;
					if (idx == IDX_W'(N - 2)) begin
						state <= x25519_pkg::SQ_FOLD2;
					end
				end
				x25519_pkg::SQ_FOLD2: begin
					state   <= x25519_pkg::SQ_IDLE;
					idx     <= '0;
					sq_done <= 1'b1;
				end
				default: state <= x25519_pkg::SQ_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Limb datapath

	always_ff @(posedge clk) begin
		case (state)
			x25519_pkg::SQ_IDLE: begin
				if (sq_start) begin
					limbs <= wide;
					carry <= '0;
				end
			end
			// Keep low byte, push the rest up
			x25519_pkg::SQ_CARRY1, x25519_pkg::SQ_CARRY2: begin
				limbs.blocks[idx] <= {{(W-8){1'b0}}, sum[7:0]};
				carry             <= sum >> 8;
			end
			// Top limb keeps 7 bits, 2^255 = 19 folds the excess into limb 0
			x25519_pkg::SQ_FOLD1: begin
				limbs.blocks[idx] <= {{(W-7){1'b0}}, sum[6:0]};
				carry             <= (sum >> 7) * W'(19);
			end
			// Final carry lands unmasked in the top limb
			x25519_pkg::SQ_FOLD2: limbs.blocks[idx] <= sum;
			default: begin
			end
		endcase
	end

	// Result limbs are the low bits of each word
	always_comb begin
		for (int k = 0; k < N; k++) begin
			sq_result.blocks[k] = limbs.blocks[k][LW-1:0];
		end
	end

	// A new squeeze only starts from idle
	a_start_idle: assert property (
		@(posedge clk) disable iff (rst) sq_start |-> state == x25519_pkg::SQ_IDLE
	);

endmodule

/* src/mult_pass.sv */
`timescale 1ns/1ns
`include "x25519_cfg.svh"

module mult_pass (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             en,
	input  logic [$clog2(`X25519_LIMBS)-1:0] index,
	input  x25519_pkg::bignum_t              a,
	input  x25519_pkg::bignum_t              b_rot,
	output logic                             out_valid,
	output logic [`X25519_WORD_WIDTH-1:0]    out
);

	localparam int W = `X25519_WORD_WIDTH;
	localparam int F = `X25519_FANIN;

	logic                  terms_valid;
	x25519_pkg::bignum32_t terms;
	logic                  level1_valid;
	logic [8*W-1:0]        level1;
	logic                  level2_valid;
	logic [2*W-1:0]        level2;

	////////////////////////////////////////////////////////////
	// Products, two cycles

	mult_pass_products products (
		.clk        (clk),
		.rst        (rst),
		.en         (en),
		.index      (index),
		.a          (a),
		.b_rot      (b_rot),
		.terms_valid(terms_valid),
		.terms      (terms)
	);

	////////////////////////////////////////////////////////////
	// Adder tree, 32 to 8 to 2 to 1

	reduction_adder #(
		.IN_BLOCKS(32), .FANIN(F), .IN_WORD_WIDTH(W), .OUT_WORD_WIDTH(W)
	) level1_add (
		.clk(clk), .rst(rst), .en(terms_valid), .din(terms),
		.dout_valid(level1_valid), .dout(level1)
	);

	reduction_adder #(
		.IN_BLOCKS(8), .FANIN(F), .IN_WORD_WIDTH(W), .OUT_WORD_WIDTH(W)
	) level2_add (
		.clk(clk), .rst(rst), .en(level1_valid), .din(level1),
		.dout_valid(level2_valid), .dout(level2)
	);

	// Last level is a plain pair sum
	reduction_adder #(
		.IN_BLOCKS(2), .FANIN(2), .IN_WORD_WIDTH(W), .OUT_WORD_WIDTH(W)
	) level3_add (
		.clk(clk), .rst(rst), .en(level2_valid), .din(level2),
		.dout_valid(out_valid), .dout(out)
	);

	////////////////////////////////////////////////////////////
	// Checks

	// Every output limb traces back to an issued pass five cycles ago
	a_valid_latency: assert property (
		@(posedge clk) disable iff (rst) out_valid |-> $past(en, 5)
	);

endmodule

/* src/mult_pass_products.sv */
`timescale 1ns/1ns
`include "x25519_cfg.svh"

module mult_pass_products (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 en,
	input  logic [$clog2(`X25519_LIMBS)-1:0]     index,
	input  x25519_pkg::bignum_t                  a,
	input  x25519_pkg::bignum_t                  b_rot,
	output logic                                 terms_valid,
	output x25519_pkg::bignum32_t                terms
);

	localparam int N = `X25519_LIMBS;
	localparam int W = `X25519_WORD_WIDTH;

	logic                  stage2_en;
	logic [N-1:0]          wrap_mask;
	x25519_pkg::bignum32_t products;

	////////////////////////////////////////////////////////////
	// Stage 1, limb products and wrap mask

	always_ff @(posedge clk) begin
		if (rst) begin
			stage2_en <= 1'b0;
		end else begin
			stage2_en <= en;
		end
	end

	// One 9x9 product per limb pair, widened to a full word
	always_ff @(posedge clk) begin
		if (en) begin
			for (int j = 0; j < N; j++) begin
				products.blocks[j] <= W'(a.blocks[j]) * W'(b_rot.blocks[j]);
				// Partner index wrapped past the top, so 2^256 folds in as 38
				wrap_mask[j] <= (j > int'(index));
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 2, conditional times 38

	always_ff @(posedge clk) begin
		if (rst) begin
			terms_valid <= 1'b0;
		end else begin
			terms_valid <= stage2_en;
		end
	end

	// Only the wrapped side of the diagonal gets scaled
	always_ff @(posedge clk) begin
		if (stage2_en) begin
			for (int j = 0; j < N; j++) begin
				if (wrap_mask[j]) begin
					terms.blocks[j] <= products.blocks[j] * W'(38);
				end else begin
					terms.blocks[j] <= products.blocks[j];
				end
			end
		end
	end

endmodule

/* src/reduction_adder.sv */
`timescale 1ns/1ns
`include "x25519_cfg.svh"

module reduction_adder #(
	parameter int IN_BLOCKS      = `X25519_LIMBS,
	parameter int FANIN          = `X25519_FANIN,
	parameter int IN_WORD_WIDTH  = `X25519_WORD_WIDTH,
	parameter int OUT_WORD_WIDTH = `X25519_WORD_WIDTH
) (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         en,
	input  logic [IN_BLOCKS*IN_WORD_WIDTH-1:0]           din,
	output logic                                         dout_valid,
	output logic [(IN_BLOCKS/FANIN)*OUT_WORD_WIDTH-1:0] dout
);

	// Number of words left after one level
	localparam int OUT_BLOCKS = IN_BLOCKS / FANIN;

	logic [OUT_BLOCKS*OUT_WORD_WIDTH-1:0] sums;

	////////////////////////////////////////////////////////////
	// Group sums

	// Each output word is the sum of FANIN adjacent input words
	always_comb begin
		logic [OUT_WORD_WIDTH-1:0] acc;
		for (int g = 0; g < OUT_BLOCKS; g++) begin
			acc = '0;
			for (int k = 0; k < FANIN; k++) begin
				// Zero extend or truncate each word to the output width
				acc = acc + OUT_WORD_WIDTH'(din[(g*FANIN+k)*IN_WORD_WIDTH +: IN_WORD_WIDTH]);
			end
			sums[g*OUT_WORD_WIDTH +: OUT_WORD_WIDTH] = acc;
		end
	end

	////////////////////////////////////////////////////////////
	// Pipeline register

	// Valid follows enable by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= en;
		end
	end

	// Data only moves when a pass is present
	always_ff @(posedge clk) begin
		if (en) begin
			dout <= sums;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Groups must tile the input exactly
	a_fanin_divides: assert property (
		@(posedge clk) (IN_BLOCKS % FANIN) == 0
	);

endmodule

/* src/x25519_cfg.svh */
`ifndef X25519_CFG_SVH
`define X25519_CFG_SVH

// Limbs per field element in radix 2^8
`define X25519_LIMBS 32

// Stored limb width with headroom for unreduced sums
`define X25519_LIMB_WIDTH 9

// Width of pass terms and pass outputs
`define X25519_WORD_WIDTH 32

// Default adder tree fan-in
`define X25519_FANIN 4

`endif

/* src/x25519_mult.sv */
`timescale 1ns/1ns
`include "x25519_cfg.svh"

module x25519_mult (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  x25519_pkg::bignum_t a,
	input  x25519_pkg::bignum_t b,
	output logic                busy,
	output logic                done,
	output x25519_pkg::bignum_t result
);

	localparam int N     = `X25519_LIMBS;
	localparam int W     = `X25519_WORD_WIDTH;
	localparam int IDX_W = $clog2(`X25519_LIMBS);

	x25519_pkg::bignum_t   a_reg;
	x25519_pkg::bignum_t   b_reg;
	x25519_pkg::bignum_t   b_rot;
	logic                  accept;
	logic                  issuing;
	logic [IDX_W-1:0]      issue_cnt;
	logic [IDX_W-1:0]      collect_cnt;
	logic                  pass_en;
	logic [IDX_W-1:0]      pass_index;
	logic                  pass_valid;
	logic [W-1:0]          pass_limb;
	x25519_pkg::bignum32_t collector;
	x25519_pkg::bignum32_t sq_wide;
	logic                  sq_start;
	logic                  sq_done;
	x25519_pkg::bignum_t   sq_result;

	// Start while busy is dropped
	assign accept = start && !busy;

	////////////////////////////////////////////////////////////
	// Control, issue and collect counters

	always_ff @(posedge clk) begin
		if (rst) begin
			busy        <= 1'b0;
			done        <= 1'b0;
			issuing     <= 1'b0;
			issue_cnt   <= '0;
			collect_cnt <= '0;
		end else begin
			done <= sq_done;
			if (accept) begin
				busy        <= 1'b1;
				issuing     <= 1'b1;
				issue_cnt   <= '0;
				collect_cnt <= '0;
			end else if (sq_done) begin
				busy <= 1'b0;
			end
			// One pass per cycle for 32 cycles
			if (issuing) begin
				issue_cnt <= issue_cnt + 1'b1;
				if (issue_cnt == IDX_W'(N - 1)) begin
					issuing <= 1'b0;
				end
			end
			// Limbs come back in issue order
			if (pass_valid) begin
				collect_cnt <= collect_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			a_reg <= a;
			b_reg <= b;
		end
		if (pass_valid) begin
			collector.blocks[collect_cnt] <= pass_limb;
		end
		if (sq_done) begin
			result <= sq_result;
		end
	end

	////////////////////////////////////////////////////////////
	// Pass issue with b rotated to (index - j) mod 32

	assign pass_en    = issuing;
	assign pass_index = issue_cnt;

	always_comb begin
		logic [IDX_W-1:0] src;
		for (int j = 0; j < N; j++) begin
			src             = issue_cnt - IDX_W'(j);
			b_rot.blocks[j] = b_reg.blocks[src];
		end
	end

	mult_pass pass (
		.clk      (clk),
		.rst      (rst),
		.en       (pass_en),
		.index    (pass_index),
		.a        (a_reg),
		.b_rot    (b_rot),
		.out_valid(pass_valid),
		.out      (pass_limb)
	);

	////////////////////////////////////////////////////////////
	// Squeeze handoff on the last limb, merged in directly

	assign sq_start = pass_valid && (collect_cnt == IDX_W'(N - 1));

	always_comb begin
		sq_wide                = collector;
		sq_wide.blocks[N - 1]  = pass_limb;
	end

	carry_squeeze squeeze (
		.clk      (clk),
		.rst      (rst),
		.sq_start (sq_start),
		.wide     (sq_wide),
		.sq_done  (sq_done),
		.sq_result(sq_result)
	);

	// Pass outputs belong to an operation in progress
	a_valid_busy: assert property (
		@(posedge clk) disable iff (rst) pass_valid |-> busy
	);

endmodule

/* src/x25519_pkg.sv */
`include "x25519_cfg.svh"

package x25519_pkg;

	////////////////////////////////////////////////////////////
	// Field element types

	// Operand or result, 32 limbs of 9 bits
	typedef struct packed {
		logic [`X25519_LIMBS-1:0][`X25519_LIMB_WIDTH-1:0] blocks;
	} bignum_t;

	// Pass terms or collected unreduced product, 32 words of 32 bits
	typedef struct packed {
		logic [`X25519_LIMBS-1:0][`X25519_WORD_WIDTH-1:0] blocks;
	} bignum32_t;

	////////////////////////////////////////////////////////////
	// Carry squeeze FSM

	// Two carry sweeps, each closed by a fold at the top limb
	typedef enum logic [2:0] {
		SQ_IDLE,
		SQ_CARRY1,
		SQ_FOLD1,
		SQ_CARRY2,
		SQ_FOLD2
	} squeeze_state_t;

endpackage

/* tests/mult_cases.txt */
// Columns: operand a, operand b, expected product after the squeeze
// Each value is 32 limbs of 8 bits as 64 hex digits, limb 31 first
0000000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000
0000000000000000000000000000000000000000000000000000000000000001 0000000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000
0000000000000000000000000000000000000000000000000000000000000000 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000000
0000000000000000000000000000000000000000000000000000000000000002 0000000000000000000000000000000000000000000000000000000000000003 0000000000000000000000000000000000000000000000000000000000000006
0000000000000000000000000000000000000000000000000000000000000302 0000000000000000000000000000000000000000000000000000000000000504 00000000000000000000000000000000000000000000000000000000000f1608
000000000000000000000000000000000000000000000000000000000000ffff 000000000000000000000000000000000000000000000000000000000000ffff 00000000000000000000000000000000000000000000000000000000fffe0001
0000000000000000000000000000000000000000000000000000000000000100 0000000000000000000000000000000000000000000000000000000000000100 0000000000000000000000000000000000000000000000000000000000010000
0100000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000100 0000000000000000000000000000000000000000000000000000000000000026
0000000000000000000000000000000100000000000000000000000000000000 0000000000000000000000000000000100000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000026
0100000000000000000000000000000000000000000000000000000000000000 0100000000000000000000000000000000000000000000000000000000000000 0026000000000000000000000000000000000000000000000000000000000000
8000000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000001 0000000000000000000000000000000000000000000000000000000000000013
8000000000000000000000000000000000000000000000000000000000000000 8000000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000169
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000001 8000000000000000000000000000000000000000000000000000000000000012
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000002 8000000000000000000000000000000000000000000000000000000000000037
0101010101010101010101010101010101010101010101010101010101010101 0000000000000000000000000000000000000000000000000000000000000100 0101010101010101010101010101010101010101010101010101010101010126
0101010101010101010101010101010101010101010101010101010101010101 0101010101010101010101010101010101010101010101010101010101010101 20456a8fb4d9ff24496e93b8de03284d7297bce2072c51769bc0e60b30557a9b
0100000000000000000000000000000000000000000000000000000000000000 0101010101010101010101010101010101010101010101010101010101010101 0126262626262626262626262626262626262626262626262626262626262626
0000000000000000000000000000000000000000000000000000000000000001 7f1e2d3c4b5a69788796a5b4c3d2e1f00f1e2d3c4b5a69788796a5b4c3d2e1f0 7f1e2d3c4b5a69788796a5b4c3d2e1f00f1e2d3c4b5a69788796a5b4c3d2e1f0
7f1e2d3c4b5a69788796a5b4c3d2e1f00f1e2d3c4b5a69788796a5b4c3d2e1f0 0000000000000000000000000000000000000000000000000000000000000001 7f1e2d3c4b5a69788796a5b4c3d2e1f00f1e2d3c4b5a69788796a5b4c3d2e1f0

/* tests/tb_x25519_mult.sv */
`timescale 1ns/1ns
`include "x25519_cfg.svh"

module tb_x25519_mult;

	localparam int CLK_HALF     = 5;
	localparam int RESET_CYCLES = 16;
	// Start sampled to done visible
	localparam int LATENCY      = 102;
	// Cycle budget per operation with idle gap and slack
	localparam int OP_CYCLES    = 120;
	localparam int MAX_CASES    = 64;
	localparam int LW           = `X25519_LIMB_WIDTH;
	localparam     CASE_FILE    = "tests/mult_cases.txt";

	logic                clk;
	logic                rst;
	logic                start;
	x25519_pkg::bignum_t a;
	x25519_pkg::bignum_t b;
	logic                busy;
	logic                done;
	x25519_pkg::bignum_t result;

	// Words in a, b, expected order with limb 0 in the lowest byte
	logic [8*`X25519_LIMBS-1:0] case_mem [0:3*MAX_CASES-1];
	int     num_cases;
	int     timeout_cycles;
	int     result_errors;
	int     flag_errors;
	int     timing_errors;
	integer seed;

	x25519_mult DUT (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.a     (a),
		.b     (b),
		.busy  (busy),
		.done  (done),
		.result(result)
	);

	initial clk = 1'b0;
	always #(CLK_HALF) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Case data

	// Per address fill marker for entries the file did not reach
	function automatic logic [8*`X25519_LIMBS-1:0] unloaded_word(input int addr);
		return {8{32'h5a3c_0000 ^ 32'(addr)}};
	endfunction

	// Byte limbs from the file widened to stored limb width
	function automatic x25519_pkg::bignum_t to_bignum(input logic [8*`X25519_LIMBS-1:0] word);
		x25519_pkg::bignum_t r;
		for (int k = 0; k < `X25519_LIMBS; k++) begin
			r.blocks[k] = LW'(word[8*k +: 8]);
		end
		return r;
	endfunction

	// Full 9-bit limbs for starts that must be dropped
	function automatic x25519_pkg::bignum_t random_operand();
		x25519_pkg::bignum_t r;
		for (int k = 0; k < `X25519_LIMBS; k++) begin
			r.blocks[k] = LW'($random(seed));
		end
		return r;
	endfunction

	task automatic load_cases();
		for (int k = 0; k < 3*MAX_CASES; k++) begin
			case_mem[k] = unloaded_word(k);
		end
		$readmemh(CASE_FILE, case_mem);
		// A case counts once its expected word was read
		num_cases = 0;
		while (num_cases < MAX_CASES &&
				case_mem[3*num_cases+2] != unloaded_word(3*num_cases+2)) begin
			num_cases++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_bignum(input int idx, input x25519_pkg::bignum_t got,
			input x25519_pkg::bignum_t expected);
		if (got !== expected) begin
			result_errors++;
			$display("ERROR %0t: case %0d result %h, expected %h", $time, idx, got, expected);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic expected);
		if (got !== expected) begin
			flag_errors++;
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	// Each step lands 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// One operation from start to the cycle after done with an optional dropped start
	task automatic run_op(input int idx, input bit inject);
		x25519_pkg::bignum_t expected;
		int cycles;
		int inject_at;
		expected  = to_bignum(case_mem[3*idx+2]);
		inject_at = 2 + ({$random(seed)} % 96);
		a         = to_bignum(case_mem[3*idx]);
		b         = to_bignum(case_mem[3*idx+1]);
		start     = 1'b1;
		@(posedge clk);
		#1;
		start  = 1'b0;
		// Edges counted from the one that sampled start
		cycles = 0;
		while (done !== 1'b1 && cycles <= LATENCY + 16) begin
			check_flag("busy while running", busy, 1'b1);
			@(posedge clk);
			#1;
			cycles++;
			// Fresh operands with start while busy
			if (inject && cycles == inject_at) begin
				a     = random_operand();
				b     = random_operand();
				start = 1'b1;
			end else begin
				start = 1'b0;
			end
		end
		start = 1'b0;
		if (done !== 1'b1) begin
			timing_errors++;
			$display("Case %0d never raised done within %0d cycles of start", idx, cycles);
		end else begin
			if (cycles != LATENCY) begin
				timing_errors++;
				$display("ERROR %0t: case %0d done after %0d cycles, expected %0d",
					$time, idx, cycles, LATENCY);
			end
			check_bignum(idx, result, expected);
			check_flag("busy with done", busy, 1'b0);
		end
		@(posedge clk);
		#1;
		check_flag("done after its pulse", done, 1'b0);
		check_flag("busy after done", busy, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// Watchdog

	initial begin : watchdog
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("Errors: %0d result, %0d flag, %0d timing",
			result_errors, flag_errors, timing_errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin : main
		int k;
		rst            = 1'b1;
		start          = 1'b0;
		a              = '0;
		b              = '0;
		seed           = 32'hf4e3_0147;
		result_errors  = 0;
		flag_errors    = 0;
		timing_errors  = 0;
		timeout_cycles = 0;
		load_cases();
		if (num_cases > 0) begin
			// Two passes over the case list
			timeout_cycles = RESET_CYCLES + 2 * num_cases * OP_CYCLES + 200;
		end

		// Outputs settle from the first edge in reset
		for (k = 0; k < RESET_CYCLES; k++) begin
			@(posedge clk);
			#1;
			check_flag("busy in reset", busy, 1'b0);
			check_flag("done in reset", done, 1'b0);
		end
		rst = 1'b0;
		idle_cycles(1);
		check_flag("busy after reset", busy, 1'b0);
		check_flag("done after reset", done, 1'b0);

		if (num_cases == 0) begin
			$display("No cases could be read from %s", CASE_FILE);
			$display("SOME TESTS FAILED");
		end else begin
			// Separate operations with random idle gaps
			for (k = 0; k < num_cases; k++) begin
				idle_cycles({$random(seed)} % 6);
				run_op(k, 1'b0);
			end
			// Back to back with a start while busy in every other one
			for (k = 0; k < num_cases; k++) begin
				run_op(k, (k % 2) == 0);
			end
			$display("Errors: %0d result, %0d flag, %0d timing",
				result_errors, flag_errors, timing_errors);
			if (result_errors + flag_errors + timing_errors == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
		end
		$finish;
	end

endmodule
